// File: common/dcache_geom_pkg.sv
package dcache_geom_pkg;

    localparam int index_width    = 6;   // 64 sets
    localparam int word_off_width = 4;   // 16 words per line
    localparam int tag_width      = 20;
    localparam int line_bits      = 512;

    typedef logic [line_bits-1:0]   line_t;
    typedef logic [tag_width-1:0]   tag_t;
    typedef logic [index_width-1:0] index_t;

    // field view of a physical address
    typedef struct packed {
        tag_t                      tag;
        index_t                    index;
        logic [word_off_width-1:0] word;
        logic [1:0]                byte_sel;
    } addr_fields_t;

    // raw word for the memory side, fields for set and lane selection
    typedef union packed {
        logic [31:0]  raw;
        addr_fields_t f;
    } dcache_addr_u;

endpackage

// File: common/dcache_req_pkg.sv
package dcache_req_pkg;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } size_t;

    typedef logic [3:0] strb_t;

    // byte lanes touched inside one word
    function automatic strb_t lane_strb(size_t size, logic [1:0] off);
        case (size)
            size_byte: lane_strb = 4'b0001 << off;
            size_half: lane_strb = 4'b0011 << off;
            default:   lane_strb = 4'b1111;
        endcase
    endfunction

    // cpu puts store data in the low bits, move it to its lane
    function automatic logic [31:0] lane_data(logic [31:0] wdata, logic [1:0] off);
        lane_data = wdata << {off, 3'b000};
    endfunction

endpackage

// File: dcache/dcache_arrays.sv
`timescale 1ns/1ps

module dcache_arrays (
    input  logic                     clk,
    input  logic                     rstn,
    input  dcache_geom_pkg::index_t  i_rd_index,
    output dcache_geom_pkg::tag_t    o_tag0,
    output dcache_geom_pkg::tag_t    o_tag1,
    output logic [1:0]               o_valid,
    output dcache_geom_pkg::line_t   o_data0,
    output dcache_geom_pkg::line_t   o_data1,
    output logic [1:0]               o_dirty,
    output logic                     o_lru_way,
    input  dcache_geom_pkg::index_t  i_wr_index,
    input  logic                     i_wr_way,
    input  logic [63:0]              i_byte_we,
    input  dcache_geom_pkg::line_t   i_wr_line,
    input  logic                     i_tag_we,
    input  dcache_geom_pkg::tag_t    i_wr_tag,
    input  logic                     i_set_dirty,
    input  logic                     i_clear_dirty,
    input  logic                     i_touch,
    input  logic                     i_touch_way
);

    dcache_geom_pkg::tag_t  tag_mem  [2][64];
    dcache_geom_pkg::line_t data_mem [2][64];

    logic [1:0][63:0]        valid;
    logic [1:0][63:0]        dirty;
    logic [63:0]             lru;           // bit set: way 1 is least recently used
    dcache_geom_pkg::index_t rd_index_q;

    // tag and data behave like block ram with a registered read
    always_ff @(posedge clk) begin
        for (int b = 0; b < 64; b++) begin
            if (i_byte_we[b]) begin
                data_mem[i_wr_way][i_wr_index][8*b +: 8] <= i_wr_line[8*b +: 8];
            end
        end
        if (i_tag_we) begin
            tag_mem[i_wr_way][i_wr_index] <= i_wr_tag;
        end
        o_tag0  <= tag_mem[0][i_rd_index];
        o_tag1  <= tag_mem[1][i_rd_index];
        o_data0 <= data_mem[0][i_rd_index];
        o_data1 <= data_mem[1][i_rd_index];
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid      <= '0;
            dirty      <= '0;
            lru        <= '0;
            rd_index_q <= '0;
        end else begin
            rd_index_q <= i_rd_index;
            if (i_tag_we) valid[i_wr_way][i_wr_index] <= 1'b1;
            if (i_set_dirty) begin
                dirty[i_wr_way][i_wr_index] <= 1'b1;
            end else if (i_clear_dirty) begin
                dirty[i_wr_way][i_wr_index] <= 1'b0;
            end
            if (i_touch) lru[i_wr_index] <= ~i_touch_way;   // other way becomes lru
        end
    end

    // flop state is read through the registered index, so same-edge updates show
    assign o_valid   = {valid[1][rd_index_q], valid[0][rd_index_q]};
    assign o_dirty   = {dirty[1][rd_index_q], dirty[0][rd_index_q]};
    assign o_lru_way = lru[rd_index_q];

endmodule

// File: dcache/dcache_lookup.sv
`timescale 1ns/1ps

module dcache_lookup (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          i_req_valid,
    input  logic                          i_req_write,
    input  dcache_geom_pkg::dcache_addr_u i_req_addr,
    input  logic [31:0]                   i_req_wdata,
    input  dcache_req_pkg::size_t         i_req_size,
    input  logic                          i_req_signed,
    output logic                          o_req_ready,
    output dcache_geom_pkg::index_t       o_rd_index,
    input  dcache_geom_pkg::tag_t         i_tag0,
    input  dcache_geom_pkg::tag_t         i_tag1,
    input  logic [1:0]                    i_valid,
    input  logic                          i_lru_way,
    output logic                          o_hit,          // raw tag match
    output logic                          o_hit_way,      // victim way on a miss
    output logic                          o_miss,
    output logic [63:0]                   o_store_we,
    output dcache_geom_pkg::line_t        o_store_line,
    output dcache_geom_pkg::index_t       o_wr_index,
    output logic                          o_set_dirty,
    output logic                          o_touch,
    output logic                          o_touch_way,
    output dcache_geom_pkg::dcache_addr_u o_req_addr,
    output logic [31:0]                   o_req_wdata,
    output dcache_req_pkg::size_t         o_req_size,
    output logic                          o_req_signed,
    output logic                          o_req_write,
    output logic                          o_lookup_valid,
    input  logic                          i_miss_busy,
    input  logic                          i_fill_done
);

    logic       accept, lookup_q, hit_now, store_hit, victim_way;
    logic [1:0] tag_hit;

    assign accept     = i_req_valid & o_req_ready;
    assign o_rd_index = i_req_addr.f.index;   // arrays sample this on the accepting edge

    always_ff @(posedge clk) begin
        if (accept) begin
            o_req_addr   <= i_req_addr;
            o_req_wdata  <= i_req_wdata;
            o_req_size   <= i_req_size;
            o_req_signed <= i_req_signed;
            o_req_write  <= i_req_write;
        end
    end

    // request stays in the stage while its miss is outstanding
    always_ff @(posedge clk) begin
        if (!rstn) lookup_q <= 1'b0;
        else       lookup_q <= accept | (lookup_q & (o_miss | i_miss_busy));
    end

    // array outputs are stale while a fill is in flight
    assign o_lookup_valid = lookup_q & ~(i_miss_busy | i_fill_done);

    assign tag_hit[0] = i_valid[0] & (i_tag0 == o_req_addr.f.tag);
    assign tag_hit[1] = i_valid[1] & (i_tag1 == o_req_addr.f.tag);
    assign o_hit      = |tag_hit;
    assign victim_way = ~i_valid[0] ? 1'b0 : (~i_valid[1] ? 1'b1 : i_lru_way);
    assign o_hit_way  = o_hit ? tag_hit[1] : victim_way;

    assign hit_now   = o_lookup_valid & o_hit;
    assign o_miss    = o_lookup_valid & ~o_hit;    // once, busy masks it afterwards
    assign store_hit = hit_now & o_req_write;

    // hold off during a miss and for the cycle a store hit writes the data array
    assign o_req_ready = ~(o_miss | i_miss_busy | store_hit);

    assign o_store_we = store_hit ?
        (64'(dcache_req_pkg::lane_strb(o_req_size, o_req_addr.f.byte_sel))
            << {o_req_addr.f.word, 2'b00}) : '0;
    assign o_store_line = {16{dcache_req_pkg::lane_data(o_req_wdata, o_req_addr.f.byte_sel)}};

    assign o_wr_index  = o_req_addr.f.index;
    assign o_set_dirty = store_hit;
    assign o_touch     = hit_now;
    assign o_touch_way = o_hit_way;

endmodule

// File: dcache/dcache_miss_unit.sv
`timescale 1ns/1ps

module dcache_miss_unit (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          i_miss,
    input  dcache_geom_pkg::dcache_addr_u i_req_addr,
    input  logic                          i_req_write,
    input  logic [31:0]                   i_req_wdata,
    input  dcache_req_pkg::size_t         i_req_size,
    input  logic                          i_victim_way,
    input  dcache_geom_pkg::tag_t         i_victim_tag,
    input  logic                          i_victim_dirty,
    input  dcache_geom_pkg::line_t        i_victim_line,
    output logic                          o_busy,
    output logic                          o_fill_done,
    output dcache_geom_pkg::line_t        o_fill_line,
    output logic [63:0]                   o_refill_we,
    output logic                          o_refill_way,
    output logic                          o_tag_we,
    output logic                          o_clear_dirty,
    output logic                          o_set_dirty,
    output logic                          o_mem_rvalid,
    input  logic                          i_mem_rready,
    output logic [31:0]                   o_mem_raddr,
    input  dcache_geom_pkg::line_t        i_mem_rdata,
    output logic                          o_mem_wvalid,
    input  logic                          i_mem_wready,
    output logic [31:0]                   o_mem_waddr,
    output dcache_geom_pkg::line_t        o_mem_wdata
);

    typedef enum logic [2:0] {
        st_idle,
        st_read,
        st_refill,
        st_writeback,
        st_done
    } state_t;

    state_t state, state_n;

    dcache_geom_pkg::line_t        ret_buf;     // return buffer
    dcache_geom_pkg::line_t        wb_line;     // writeback buffer
    dcache_geom_pkg::dcache_addr_u wb_addr;
    logic                          wb_dirty;
    logic                          victim_way_q;

    logic [63:0]            line_strb;
    dcache_geom_pkg::line_t line_mask, merged;

    always_ff @(posedge clk) begin
        if (!rstn) state <= st_idle;
        else       state <= state_n;
    end

    always_comb begin
        state_n = state;
        case (state)
            st_idle:      if (i_miss) state_n = st_read;
            st_read:      if (i_mem_rready) state_n = st_refill;
            st_refill:    state_n = wb_dirty ? st_writeback : st_done;
            st_writeback: if (i_mem_wready) state_n = st_done;
            st_done:      state_n = st_idle;
            default:      state_n = st_idle;
        endcase
    end

    // store bytes of a store miss land on top of the fetched line
    always_comb begin
        line_strb = 64'(dcache_req_pkg::lane_strb(i_req_size, i_req_addr.f.byte_sel))
                    << {i_req_addr.f.word, 2'b00};
        for (int b = 0; b < 64; b++) begin
            line_mask[8*b +: 8] = {8{line_strb[b]}};
        end
        merged = (i_mem_rdata & ~line_mask)
               | ({16{dcache_req_pkg::lane_data(i_req_wdata, i_req_addr.f.byte_sel)}}
                  & line_mask);
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && i_miss) begin   // victim is only visible in the miss cycle
            wb_line      <= i_victim_line;
            wb_dirty     <= i_victim_dirty;
            victim_way_q <= i_victim_way;
            wb_addr.raw  <= {i_victim_tag, i_req_addr.f.index, 6'b0};
        end
        if (state == st_read && i_mem_rready) begin
            ret_buf <= i_req_write ? merged : i_mem_rdata;
        end
    end

    assign o_busy      = (state == st_read) || (state == st_refill) || (state == st_writeback);
    assign o_fill_done = (state == st_done);
    assign o_fill_line = ret_buf;

    assign o_refill_we   = {64{state == st_refill}};
    assign o_refill_way  = victim_way_q;
    assign o_tag_we      = (state == st_refill);
    assign o_set_dirty   = (state == st_refill) & i_req_write;
    assign o_clear_dirty = (state == st_refill) & ~i_req_write;

    assign o_mem_rvalid = (state == st_read);
    assign o_mem_raddr  = {i_req_addr.f.tag, i_req_addr.f.index, 6'b0};   // line aligned
    assign o_mem_wvalid = (state == st_writeback);
    assign o_mem_waddr  = wb_addr.raw;
    assign o_mem_wdata  = wb_line;

endmodule

// File: dcache/dcache_load_align.sv
`timescale 1ns/1ps

module dcache_load_align (
    input  dcache_geom_pkg::line_t        i_line,
    input  dcache_geom_pkg::dcache_addr_u i_addr,
    input  dcache_req_pkg::size_t         i_size,
    input  logic                          i_signed,
    output logic [31:0]                   o_rdata
);

    logic [31:0] word;
    logic [15:0] half;
    logic [7:0]  byte_val;

    always_comb begin
        word     = i_line[{i_addr.f.word, 5'b0} +: 32];
        half     = word[{i_addr.f.byte_sel[1], 4'b0} +: 16];
        byte_val = word[{i_addr.f.byte_sel, 3'b0} +: 8];
        case (i_size)
            dcache_req_pkg::size_byte: o_rdata = {{24{i_signed & byte_val[7]}}, byte_val};
            dcache_req_pkg::size_half: o_rdata = {{16{i_signed & half[15]}}, half};
            default:                   o_rdata = word;
        endcase
    end

endmodule

// File: dcache/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   i_req_valid,
    input  logic                   i_req_write,
    input  logic [31:0]            i_req_addr,
    input  logic [31:0]            i_req_wdata,
    input  dcache_req_pkg::size_t  i_req_size,
    input  logic                   i_req_signed,
    output logic                   o_req_ready,
    output logic                   o_resp_valid,
    output logic [31:0]            o_resp_rdata,
    input  logic                   i_mem_rready,
    input  dcache_geom_pkg::line_t i_mem_rdata,
    output logic                   o_mem_rvalid,
    output logic [31:0]            o_mem_raddr,
    input  logic                   i_mem_wready,
    output logic                   o_mem_wvalid,
    output logic [31:0]            o_mem_waddr,
    output dcache_geom_pkg::line_t o_mem_wdata
);

    dcache_geom_pkg::index_t       rd_index, wr_index;
    dcache_geom_pkg::tag_t         tag0, tag1;
    dcache_geom_pkg::line_t        data0, data1, store_line, fill_line;
    dcache_geom_pkg::dcache_addr_u req_addr;
    dcache_req_pkg::size_t         req_size;
    logic [1:0]  valid, dirty;
    logic [63:0] store_we, refill_we;
    logic [31:0] req_wdata;
    logic lru_way, hit, hit_way, miss, l_set_dirty, touch, touch_way;
    logic req_signed, req_write, lookup_valid;
    logic miss_busy, fill_done, refill_way, tag_we, clear_dirty, m_set_dirty;

    // a hit answers from the arrays, a fill from the return buffer
    assign o_resp_valid = (lookup_valid & hit) | fill_done;

    dcache_arrays u_arrays (
        .clk(clk), .rstn(rstn), .i_rd_index(rd_index),
        .o_tag0(tag0), .o_tag1(tag1), .o_valid(valid), .o_data0(data0), .o_data1(data1),
        .o_dirty(dirty), .o_lru_way(lru_way), .i_wr_index(wr_index),
        .i_wr_way(miss_busy ? refill_way : hit_way), .i_byte_we(store_we | refill_we),
        .i_wr_line(miss_busy ? fill_line : store_line), .i_tag_we(tag_we),
        .i_wr_tag(req_addr.f.tag), .i_set_dirty(l_set_dirty | m_set_dirty),
        .i_clear_dirty(clear_dirty), .i_touch(touch | tag_we),
        .i_touch_way(miss_busy ? refill_way : touch_way)
    );

    dcache_lookup u_lookup (
        .clk(clk), .rstn(rstn), .i_req_valid(i_req_valid), .i_req_write(i_req_write),
        .i_req_addr(i_req_addr), .i_req_wdata(i_req_wdata), .i_req_size(i_req_size),
        .i_req_signed(i_req_signed), .o_req_ready(o_req_ready), .o_rd_index(rd_index),
        .i_tag0(tag0), .i_tag1(tag1), .i_valid(valid), .i_lru_way(lru_way),
        .o_hit(hit), .o_hit_way(hit_way), .o_miss(miss), .o_store_we(store_we),
        .o_store_line(store_line), .o_wr_index(wr_index), .o_set_dirty(l_set_dirty),
        .o_touch(touch), .o_touch_way(touch_way), .o_req_addr(req_addr),
        .o_req_wdata(req_wdata), .o_req_size(req_size), .o_req_signed(req_signed),
        .o_req_write(req_write), .o_lookup_valid(lookup_valid),
        .i_miss_busy(miss_busy), .i_fill_done(fill_done)
    );

    dcache_miss_unit u_miss (
        .clk(clk), .rstn(rstn), .i_miss(miss), .i_req_addr(req_addr),
        .i_req_write(req_write), .i_req_wdata(req_wdata), .i_req_size(req_size),
        .i_victim_way(hit_way), .i_victim_tag(hit_way ? tag1 : tag0),
        .i_victim_dirty(dirty[hit_way]), .i_victim_line(hit_way ? data1 : data0),
        .o_busy(miss_busy), .o_fill_done(fill_done), .o_fill_line(fill_line),
        .o_refill_we(refill_we), .o_refill_way(refill_way), .o_tag_we(tag_we),
        .o_clear_dirty(clear_dirty), .o_set_dirty(m_set_dirty),
        .o_mem_rvalid(o_mem_rvalid), .i_mem_rready(i_mem_rready),
        .o_mem_raddr(o_mem_raddr), .i_mem_rdata(i_mem_rdata),
        .o_mem_wvalid(o_mem_wvalid), .i_mem_wready(i_mem_wready),
        .o_mem_waddr(o_mem_waddr), .o_mem_wdata(o_mem_wdata)
    );

    dcache_load_align u_align (
        .i_line(fill_done ? fill_line : (hit_way ? data1 : data0)),
        .i_addr(req_addr), .i_size(req_size), .i_signed(req_signed),
        .o_rdata(o_resp_rdata)
    );

endmodule

// File: sim/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
    output logic o_clk,
    output logic o_rstn
);

    initial begin
        o_clk = 1'b0;
        forever #4 o_clk = ~o_clk;   // 8 ns period
    end

    initial begin
        o_rstn = 1'b0;
        repeat (16) @(posedge o_clk);
        #1 o_rstn = 1'b1;
    end

endmodule

// File: sim/mem_model.sv
`timescale 1ns/1ps

module mem_model (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   i_rvalid,
    input  logic [31:0]            i_raddr,
    output logic                   o_rready,
    output dcache_geom_pkg::line_t o_rdata,
    input  logic                   i_wvalid,
    input  logic [31:0]            i_waddr,
    input  dcache_geom_pkg::line_t i_wdata,
    output logic                   o_wready
);

    dcache_geom_pkg::line_t lines [logic [25:0]];   // only lines written back live here
    int   rd_wait;
    int   wr_wait;
    logic rd_armed;
    logic wr_armed;

    // untouched memory follows the fill rule, word = byte address ^ 0xa5a50000
    function automatic dcache_geom_pkg::line_t fetch_line(input logic [31:0] addr);
        dcache_geom_pkg::line_t l;
        logic [31:0]            base;
        base = {addr[31:6], 6'b0};
        if (lines.exists(addr[31:6])) begin
            l = lines[addr[31:6]];
        end else begin
            for (int w = 0; w < 16; w++) begin
                l[32*w +: 32] = (base + 32'(4 * w)) ^ 32'hA5A5_0000;
            end
        end
        return l;
    endfunction

    initial begin
        o_rready = 1'b0;
        o_wready = 1'b0;
        o_rdata  = '0;
        rd_armed = 1'b0;
        wr_armed = 1'b0;
        rd_wait  = 0;
        wr_wait  = 0;
        forever begin
            @(posedge clk);
            #1;
            o_rready = 1'b0;   // ready is a one-cycle pulse
            o_wready = 1'b0;
            if (rstn && i_rvalid) begin
                if (!rd_armed) begin
                    rd_wait  = int'($urandom % 8);   // 0..7 cycles
                    rd_armed = 1'b1;
                end
                if (rd_wait == 0) begin
                    o_rdata  = fetch_line(i_raddr);
                    o_rready = 1'b1;
                    rd_armed = 1'b0;
                end else begin
                    rd_wait--;
                end
            end
            if (rstn && i_wvalid) begin
                if (!wr_armed) begin
                    wr_wait  = int'($urandom % 8);
                    wr_armed = 1'b1;
                end
                if (wr_wait == 0) begin
                    lines[i_waddr[31:6]] = i_wdata;   // data is held until the handshake
                    o_wready = 1'b1;
                    wr_armed = 1'b0;
                end else begin
                    wr_wait--;
                end
            end
        end
    end

endmodule

// File: sim/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;

    // 5 tests x 40 requests x 30 cycles per miss with writeback x margin 3
    localparam int max_cycles = 5 * 40 * 30 * 3;

    logic                   clk, rstn;
    logic                   req_valid, req_write, req_signed, req_ready;
    logic [31:0]            req_addr, req_wdata;
    dcache_req_pkg::size_t  req_size;
    logic                   resp_valid;
    logic [31:0]            resp_rdata;
    logic                   mem_rvalid, mem_rready, mem_wvalid, mem_wready;
    logic [31:0]            mem_raddr, mem_waddr;
    dcache_geom_pkg::line_t mem_rdata, mem_wdata;

    int          cycle = 0;
    int          rd_count = 0;
    int          wr_count = 0;
    logic [31:0] last_waddr;
    logic [31:0] shadow [logic [29:0]];   // reference memory, word addressed

    // one entry per accepted request, oldest first
    logic [31:0] exp_q [$];
    bit          load_q [$];
    int          acc_q [$];
    bit          fast_q [$];

    tb_clkgen u_clk (.o_clk(clk), .o_rstn(rstn));

    dcache_top uut (
        .clk(clk), .rstn(rstn), .i_req_valid(req_valid), .i_req_write(req_write),
        .i_req_addr(req_addr), .i_req_wdata(req_wdata), .i_req_size(req_size),
        .i_req_signed(req_signed), .o_req_ready(req_ready), .o_resp_valid(resp_valid),
        .o_resp_rdata(resp_rdata), .i_mem_rready(mem_rready), .i_mem_rdata(mem_rdata),
        .o_mem_rvalid(mem_rvalid), .o_mem_raddr(mem_raddr), .i_mem_wready(mem_wready),
        .o_mem_wvalid(mem_wvalid), .o_mem_waddr(mem_waddr), .o_mem_wdata(mem_wdata)
    );

    mem_model u_mem (
        .clk(clk), .rstn(rstn), .i_rvalid(mem_rvalid), .i_raddr(mem_raddr),
        .o_rready(mem_rready), .o_rdata(mem_rdata), .i_wvalid(mem_wvalid),
        .i_waddr(mem_waddr), .i_wdata(mem_wdata), .o_wready(mem_wready)
    );

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
            $display("Regression failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    function automatic logic [31:0] word_at(input logic [31:0] addr);
        if (shadow.exists(addr[31:2])) return shadow[addr[31:2]];
        else return {addr[31:2], 2'b00} ^ 32'hA5A5_0000;
    endfunction

    function automatic void store_ref(input logic [31:0] addr, input logic [31:0] data,
                                      input dcache_req_pkg::size_t size);
        logic [31:0] w;
        w = word_at(addr);
        case (size)
            dcache_req_pkg::size_byte: w[8*addr[1:0] +: 8] = data[7:0];
            dcache_req_pkg::size_half: w[16*addr[1] +: 16] = data[15:0];
            default:                   w = data;
        endcase
        shadow[addr[31:2]] = w;
    endfunction

    // little endian lanes, sign or zero extension to 32 bits
    function automatic logic [31:0] load_ref(input logic [31:0] addr,
                                             input dcache_req_pkg::size_t size,
                                             input logic sgn);
        logic [31:0] w;
        logic [15:0] h;
        logic [7:0]  b;
        w = word_at(addr);
        b = 8'(w >> (8 * addr[1:0]));
        h = 16'(w >> (addr[1] ? 16 : 0));
        case (size)
            dcache_req_pkg::size_byte: return sgn ? {{24{b[7]}}, b} : {24'b0, b};
            dcache_req_pkg::size_half: return sgn ? {{16{h[15]}}, h} : {16'b0, h};
            default:                   return w;
        endcase
    endfunction

    // idle outputs once reset is released
    task automatic idle_after_reset();
        check("o_req_ready", 32'(req_ready), 32'd1);
        check("o_resp_valid", 32'(resp_valid), 32'd0);
        check("o_mem_rvalid", 32'(mem_rvalid), 32'd0);
        check("o_mem_wvalid", 32'(mem_wvalid), 32'd0);
    endtask

    // called just after a rising edge, returns just after the accepting edge
    task automatic issue(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                         input dcache_req_pkg::size_t size, input logic sgn, input bit fast);
        req_valid  = 1'b1;
        req_write  = wr;
        req_addr   = addr;
        req_wdata  = wdata;
        req_size   = size;
        req_signed = sgn;
        @(negedge clk);
        while (!req_ready) @(negedge clk);
        if (wr) begin
            store_ref(addr, wdata, size);
            exp_q.push_back(32'h0);
        end else begin
            exp_q.push_back(load_ref(addr, size, sgn));
        end
        load_q.push_back(!wr);
        acc_q.push_back(cycle);
        fast_q.push_back(fast);
        @(posedge clk);
        #1;
    endtask

    task automatic drain();
        req_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic cold_load(input logic [31:0] base);
        int          r0;
        logic [31:0] a;
        a  = base + 32'h0000_1008;
        r0 = rd_count;
        issue(1'b0, a, 32'h0, dcache_req_pkg::size_word, 1'b0, 1'b0);
        drain();
        check("cold load mem reads", 32'(rd_count - r0), 32'd1);
        r0 = rd_count;
        issue(1'b0, a + 32'h14, 32'h0, dcache_req_pkg::size_word, 1'b0, 1'b0);
        drain();
        check("same line mem reads", 32'(rd_count - r0), 32'd0);
    endtask

    task automatic store_merge(input logic [31:0] base);
        logic [31:0] x;
        x = base + 32'h0000_2040;
        issue(1'b1, x + 32'h1, 32'h0000_005A, dcache_req_pkg::size_byte, 1'b0, 1'b0); // miss
        issue(1'b1, x + 32'h2, 32'h0000_8001, dcache_req_pkg::size_half, 1'b0, 1'b0);
        issue(1'b1, x + 32'h4, 32'hFEDC_BA98, dcache_req_pkg::size_word, 1'b0, 1'b0);
        issue(1'b1, x + 32'h7, 32'h0000_0080, dcache_req_pkg::size_byte, 1'b0, 1'b0);
        issue(1'b1, x + 32'h4, 32'h0000_7FF3, dcache_req_pkg::size_half, 1'b0, 1'b0);
        // reads the bytes the store hit just wrote
        issue(1'b0, x + 32'h4, 32'h0, dcache_req_pkg::size_word, 1'b0, 1'b0);
        for (int off = 0; off < 8; off++) begin
            issue(1'b0, x + 32'(off), 32'h0, dcache_req_pkg::size_byte, 1'b1, 1'b0);
            issue(1'b0, x + 32'(off), 32'h0, dcache_req_pkg::size_byte, 1'b0, 1'b0);
        end
        for (int off = 0; off < 8; off += 2) begin
            issue(1'b0, x + 32'(off), 32'h0, dcache_req_pkg::size_half, 1'b1, 1'b0);
            issue(1'b0, x + 32'(off), 32'h0, dcache_req_pkg::size_half, 1'b0, 1'b0);
        end
        issue(1'b0, x, 32'h0, dcache_req_pkg::size_word, 1'b0, 1'b0);
        issue(1'b0, x + 32'h4, 32'h0, dcache_req_pkg::size_word, 1'b1, 1'b0);
        drain();
    endtask

    task automatic hit_stream(input logic [31:0] base);
        int          r0;
        logic [31:0] y;
        y = base + 32'h0000_3000;
        issue(1'b0, y, 32'h0, dcache_req_pkg::size_word, 1'b0, 1'b0);   // bring the line in
        drain();
        r0 = rd_count;
        for (int i = 0; i < 16; i++) begin
            issue(1'b0, y + 32'(4 * i), 32'h0, dcache_req_pkg::size_word, 1'b0, 1'b1);
        end
        issue(1'b0, y + 32'h6, 32'h0, dcache_req_pkg::size_half, 1'b1, 1'b1);
        issue(1'b0, y + 32'h3, 32'h0, dcache_req_pkg::size_byte, 1'b1, 1'b1);
        drain();
        check("hit stream mem reads", 32'(rd_count - r0), 32'd0);
    endtask

    task automatic lru_evict(input logic [31:0] base);
        int          r0;
        logic [31:0] a, b, c;
        a = base + 32'h0001_0140;   // set 5
        b = a + 32'h1000;
        c = a + 32'h2000;
        issue(1'b0, a, 32'h0, dcache_req_pkg::size_word, 1'b0, 1'b0);
        issue(1'b0, b, 32'h0, dcache_req_pkg::size_word, 1'b0, 1'b0);
        issue(1'b0, a + 32'h8, 32'h0, dcache_req_pkg::size_word, 1'b0, 1'b0);
        issue(1'b0, c, 32'h0, dcache_req_pkg::size_word, 1'b0, 1'b0);
        drain();
        r0 = rd_count;
        issue(1'b0, a + 32'h3c, 32'h0, dcache_req_pkg::size_word, 1'b0, 1'b0);
        drain();
        check("lru kept line reads", 32'(rd_count - r0), 32'd0);
        r0 = rd_count;
        issue(1'b0, b + 32'h10, 32'h0, dcache_req_pkg::size_word, 1'b0, 1'b0);
        drain();
        check("lru evicted line reads", 32'(rd_count - r0), 32'd1);
    endtask

    task automatic dirty_evict(input logic [31:0] base);
        int          w0;
        logic [31:0] d;
        d  = base + 32'h0002_0240;   // set 9
        w0 = wr_count;
        issue(1'b1, d + 32'h8, 32'h1234_5678, dcache_req_pkg::size_word, 1'b0, 1'b0);
        issue(1'b1, d + 32'h5, 32'h0000_00C3, dcache_req_pkg::size_byte, 1'b0, 1'b0);
        issue(1'b0, d + 32'h1000, 32'h0, dcache_req_pkg::size_word, 1'b0, 1'b0);
        issue(1'b0, d + 32'h2000, 32'h0, dcache_req_pkg::size_word, 1'b0, 1'b0);
        drain();
        check("dirty evict mem writes", 32'(wr_count - w0), 32'd1);
        check("mem write address", last_waddr, d);
        issue(1'b0, d + 32'h8, 32'h0, dcache_req_pkg::size_word, 1'b0, 1'b0);
        issue(1'b0, d + 32'h5, 32'h0, dcache_req_pkg::size_byte, 1'b1, 1'b0);
        issue(1'b0, d + 32'h4, 32'h0, dcache_req_pkg::size_word, 1'b0, 1'b0);
        drain();
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= max_cycles) begin
            $display("Regression failed");
            $fatal(1, "simulation timed out at cycle %0d", cycle);
        end
    end

    // handshakes complete at the next rising edge
    always @(negedge clk) begin : mem_counter
        if (rstn && mem_rvalid && mem_rready) begin
            rd_count++;
            check("o_mem_raddr offset", 32'(mem_raddr[5:0]), 32'd0);   // line aligned
        end
        if (rstn && mem_wvalid && mem_wready) begin
            wr_count++;
            last_waddr = mem_waddr;
        end
    end

    always @(negedge clk) begin : resp_monitor
        logic [31:0] exp_data;
        bit          is_load;
        bit          fast;
        int          acc;
        if (rstn && resp_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("response at %0t with no request outstanding", $time);
                $display("Regression failed");
                $fatal(1, "unexpected response");
            end else begin
                exp_data = exp_q.pop_front();
                is_load  = load_q.pop_front();
                acc      = acc_q.pop_front();
                fast     = fast_q.pop_front();
                if (is_load) check("o_resp_rdata", resp_rdata, exp_data);
                if (fast) check("hit response latency", 32'(cycle - acc), 32'd1);
            end
        end
    end

    initial begin
        req_valid  = 1'b0;
        req_write  = 1'b0;
        req_addr   = '0;
        req_wdata  = '0;
        req_size   = dcache_req_pkg::size_word;
        req_signed = 1'b0;
        void'($urandom(92));
        wait (rstn === 1'b1);
        @(posedge clk);
        #1;
        idle_after_reset();
        for (int round = 0; round < 2; round++) begin   // second round on fresh tags
            cold_load(32'(round) << 20);
            store_merge(32'(round) << 20);
            hit_stream(32'(round) << 20);
            lru_evict(32'(round) << 20);
            dirty_evict(32'(round) << 20);
        end
        drain();
        $display("Regression passed");
        $finish;
    end

endmodule

// File: dcache.f
common/dcache_geom_pkg.sv
common/dcache_req_pkg.sv
dcache/dcache_arrays.sv
dcache/dcache_lookup.sv
dcache/dcache_miss_unit.sv
dcache/dcache_load_align.sv
dcache/dcache_top.sv
sim/tb_clkgen.sv
sim/mem_model.sv
sim/tb_dcache.sv

// File: Makefile
# Verilator flow for the data cache

TOP = tb_dcache

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f dcache.f

# the binary exits non-zero on $$fatal, so make fails with it
sim:
	verilator --binary --top-module $(TOP) -f dcache.f -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
